// ==== icache_top.f ====
src/icache_pkg.sv
src/icache_line_store.sv
src/icache_fetch_ctrl.sv
src/icache_perf_counters.sv
src/icache_top.sv
testbench/axi_read_model.sv
testbench/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the icache testbench with Verilator, runs it and looks for the pass line
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module icache_tb -Mdir obj_dir -f icache_top.f; then
  echo "verilator build failed"
  exit 1
fi

output="$(./obj_dir/Vicache_tb)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test completed successfully" <<< "$output"; then
  exit 0
fi

echo "pass line not found in simulation output"
exit 1

// ==== src/icache_fetch_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_fetch_ctrl
  import icache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic [31:0]           fetch_addr,
  input  logic                  fetch_valid,
  output logic                  fetch_ready,
  output logic                  result_valid,
  output logic [31:0]           fetch_data,
  output axi_r_m2s_t            mem_req,
  input  axi_r_s2m_t            mem_rsp,
  output logic [index_bits-1:0] rd_index,
  input  line_entry_t           rd_entry,
  output logic                  wr_en,
  output logic [index_bits-1:0] wr_index,
  output line_entry_t           wr_entry,
  output logic                  hit_pulse,
  output logic                  miss_pulse,
  output logic                  skip_pulse
);

  typedef enum logic [2:0] {
    st_idle,
    st_skip,
    st_burst,
    st_flash_begin,
    st_flash_end
  } state_e;

  state_e state, state_next;

  logic                 ar_valid;
  logic [31:0]          ar_addr;
  logic [7:0]           ar_len;
  logic                 r_ready;
  logic [31:0]          req_addr;
  logic [word_bits-1:0] beat_cnt;
  logic [word_bits-1:0] fill_pos;
  line_data_u           line_buf;

  logic                 accept;
  logic                 is_skip;
  logic                 is_burst;
  logic                 tag_match;
  logic                 cached_hit;
  logic                 beat_take;

  // request decode, valid only in idle
  assign rd_index = fetch_addr[line_offset_bits +: index_bits];
  assign is_skip = fetch_addr < skip_limit;
  assign is_burst = fetch_addr >= burst_base;
  assign tag_match = rd_entry.tag == fetch_addr[31 -: tag_bits];
  assign cached_hit = !is_skip && rd_entry.valid && tag_match;
  assign accept = (state == st_idle) && fetch_valid && fetch_ready;

  // a beat is taken once, rready follows one cycle later
  assign beat_take = (state == st_skip || state == st_burst || state == st_flash_begin) &&
                     mem_rsp.rvalid && !r_ready;

  // critical word first, then wrap around the line
  assign fill_pos = req_addr[line_offset_bits-1:2] + beat_cnt;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (accept) begin
          if (is_skip) begin
            state_next = st_skip;
          end else if (cached_hit) begin
            state_next = st_idle;
          end else if (is_burst) begin
            state_next = st_burst;
          end else begin
            state_next = st_flash_begin;
          end
        end
      end
      st_skip: begin
        if (beat_take) begin
          state_next = st_idle;
        end
      end
      st_burst: begin
        if (beat_take && mem_rsp.rlast) begin
          state_next = st_idle;
        end
      end
      st_flash_begin: begin
        if (beat_take) begin
          state_next = st_flash_end;
        end
      end
      st_flash_end: begin
        if (beat_cnt == '0) begin
          state_next = st_idle;
        end else begin
          state_next = st_flash_begin;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_valid <= 1'b0;
      r_ready <= 1'b0;
      beat_cnt <= '0;
      fetch_ready <= 1'b1;
      result_valid <= 1'b0;
      wr_en <= 1'b0;
      hit_pulse <= 1'b0;
      miss_pulse <= 1'b0;
      skip_pulse <= 1'b0;
    end else begin
      // next flash word goes out after each single read
      if (accept && !cached_hit) begin
        ar_valid <= 1'b1;
      end else if (state == st_flash_end && beat_cnt != '0) begin
        ar_valid <= 1'b1;
      end else if (ar_valid && mem_rsp.arready) begin
        ar_valid <= 1'b0;
      end

      r_ready <= beat_take;

      if (accept) begin
        beat_cnt <= '0;
      end else if (beat_take) begin
        beat_cnt <= beat_cnt + word_bits'(1);
      end

      // after a refill ready comes back one cycle after the write
      if (accept && !cached_hit) begin
        fetch_ready <= 1'b0;
      end else if (state == st_idle || (state == st_skip && beat_take)) begin
        fetch_ready <= 1'b1;
      end

      result_valid <= (accept && cached_hit) || (beat_take && beat_cnt == '0);

      wr_en <= (state == st_burst && beat_take && mem_rsp.rlast) ||
               (state == st_flash_end && beat_cnt == '0);

      hit_pulse <= accept && cached_hit;
      miss_pulse <= accept && !is_skip && !cached_hit;
      skip_pulse <= accept && is_skip;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_addr <= fetch_addr;
      ar_addr <= {fetch_addr[31:2], 2'b00};
      ar_len <= is_burst ? 8'd7 : 8'd0;
    end else if (state == st_flash_end) begin
      ar_addr <= {req_addr[31:line_offset_bits], fill_pos, 2'b00};
    end

    if (beat_take) begin
      line_buf.words[fill_pos] <= mem_rsp.rdata;
    end

    if (accept && cached_hit) begin
      fetch_data <= rd_entry.data.words[fetch_addr[line_offset_bits-1:2]];
    end else if (beat_take && beat_cnt == '0) begin
      fetch_data <= mem_rsp.rdata;
    end
  end

  always_comb begin
    mem_req.arvalid = ar_valid;
    mem_req.araddr = ar_addr;
    mem_req.arlen = ar_len;
    mem_req.arsize = word_size_code;
    mem_req.arburst = burst_wrap;
    mem_req.rready = r_ready;
  end

  // full line written with the tag of the missing address
  assign wr_index = req_addr[line_offset_bits +: index_bits];

  always_comb begin
    wr_entry.valid = 1'b1;
    wr_entry.tag = req_addr[31 -: tag_bits];
    wr_entry.data = line_buf;
  end

endmodule

`default_nettype wire

// ==== src/icache_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_line_store
  import icache_pkg::*;
(
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  fencei,
  input  logic [index_bits-1:0] rd_index,
  output line_entry_t           rd_entry,
  input  logic                  wr_en,
  input  logic [index_bits-1:0] wr_index,
  input  line_entry_t           wr_entry
);

  localparam int num_lines = 1 << index_bits;

  logic [num_lines-1:0] valid_q;
  logic [tag_bits-1:0] tag_q [num_lines];
  logic [words_per_line*32-1:0] data_q [num_lines];

  // fencei overrides a write in the same cycle
  always_ff @(posedge clock) begin
    if (reset || fencei) begin
      valid_q <= '0;
    end else if (wr_en) begin
      valid_q[wr_index] <= wr_entry.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_q[wr_index] <= wr_entry.tag;
      data_q[wr_index] <= wr_entry.data.flat;
    end
  end

  // combinational read port
  always_comb begin
    rd_entry.valid = valid_q[rd_index];
    rd_entry.tag = tag_q[rd_index];
    rd_entry.data.flat = data_q[rd_index];
  end

endmodule

`default_nettype wire

// ==== src/icache_perf_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_perf_counters
  import icache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         hit_pulse,
  input  logic         miss_pulse,
  input  logic         skip_pulse,
  output perf_counts_t counts
);

  // holds at all ones instead of wrapping
  function automatic logic [31:0] sat_inc(input logic [31:0] value);
    if (&value) begin
      return value;
    end
    return value + 32'd1;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      counts <= '0;
    end else begin
      if (hit_pulse) begin
        counts.hits <= sat_inc(counts.hits);
      end
      if (miss_pulse) begin
        counts.misses <= sat_inc(counts.misses);
      end
      if (skip_pulse) begin
        counts.skips <= sat_inc(counts.skips);
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // line geometry
  localparam int line_offset_bits = 5;
  localparam int index_bits = 4;
  localparam int tag_bits = 23;
  localparam int words_per_line = 8;
  localparam int word_bits = $clog2(words_per_line);

  // address regions
  localparam logic [31:0] skip_limit = 32'h3000_0000;
  localparam logic [31:0] burst_base = 32'ha000_0000;

  // AR channel encodings
  localparam logic [1:0] burst_wrap = 2'b10;
  localparam logic [2:0] word_size_code = 3'd2;

  typedef struct packed {
    logic        arvalid;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [2:0]  arsize;
    logic [1:0]  arburst;
    logic        rready;
  } axi_r_m2s_t;

  typedef struct packed {
    logic        arready;
    logic        rvalid;
    logic        rlast;
    logic [31:0] rdata;
  } axi_r_s2m_t;

  // one line, flat for storage or split into fetch words
  typedef union packed {
    logic [words_per_line*32-1:0]        flat;
    logic [words_per_line-1:0][31:0]     words;
  } line_data_u;

  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
    line_data_u          data;
  } line_entry_t;

  typedef struct packed {
    logic [31:0] hits;
    logic [31:0] misses;
    logic [31:0] skips;
  } perf_counts_t;

endpackage

`default_nettype wire

// ==== src/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top
  import icache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic [31:0]  fetch_addr,
  input  logic         fetch_valid,
  output logic         fetch_ready,
  output logic         result_valid,
  output logic [31:0]  fetch_data,
  input  logic         fencei,
  output axi_r_m2s_t   mem_req,
  input  axi_r_s2m_t   mem_rsp,
  output perf_counts_t counts
);

  logic [index_bits-1:0] rd_index;
  line_entry_t           rd_entry;
  logic                  wr_en;
  logic [index_bits-1:0] wr_index;
  line_entry_t           wr_entry;
  logic                  hit_pulse;
  logic                  miss_pulse;
  logic                  skip_pulse;

  icache_fetch_ctrl u_ctrl (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .result_valid (result_valid),
    .fetch_data   (fetch_data),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .rd_index     (rd_index),
    .rd_entry     (rd_entry),
    .wr_en        (wr_en),
    .wr_index     (wr_index),
    .wr_entry     (wr_entry),
    .hit_pulse    (hit_pulse),
    .miss_pulse   (miss_pulse),
    .skip_pulse   (skip_pulse)
  );

  icache_line_store u_store (
    .clock    (clock),
    .reset    (reset),
    .fencei   (fencei),
    .rd_index (rd_index),
    .rd_entry (rd_entry),
    .wr_en    (wr_en),
    .wr_index (wr_index),
    .wr_entry (wr_entry)
  );

  icache_perf_counters u_counters (
    .clock      (clock),
    .reset      (reset),
    .hit_pulse  (hit_pulse),
    .miss_pulse (miss_pulse),
    .skip_pulse (skip_pulse),
    .counts     (counts)
  );

endmodule

`default_nettype wire

// ==== testbench/axi_read_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_read_model
  import icache_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  axi_r_m2s_t mem_req,
  output axi_r_s2m_t mem_rsp
);

  localparam logic [31:0] seed = 32'hd7a1_2435;

  axi_r_s2m_t  rsp_q = '0;
  logic        busy = 1'b0;
  logic [31:0] addr;
  logic [31:0] wrap_mask;
  logic [7:0]  beats_left;
  logic [1:0]  delay;
  logic [31:0] rng;

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // word contents are a hash of the word address
  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    logic [31:0] h;
    h = {2'b00, byte_addr[31:2]} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    return h ^ (h >> 13);
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      rsp_q <= '0;
      busy <= 1'b0;
      delay <= 2'd0;
      rng <= seed;
    end else if (!busy) begin
      if (mem_req.arvalid && rsp_q.arready) begin
        rsp_q.arready <= 1'b0;
        busy <= 1'b1;
        addr <= mem_req.araddr;
        beats_left <= mem_req.arlen;
        // wrap boundary is the total burst size
        if (mem_req.arburst == burst_wrap) begin
          wrap_mask <= (({24'd0, mem_req.arlen} + 32'd1) << 2) - 32'd1;
        end else begin
          wrap_mask <= 32'hffff_ffff;
        end
        rng <= xorshift(rng);
        delay <= rng[1:0];
      end else if (mem_req.arvalid) begin
        if (delay == 2'd0) begin
          rsp_q.arready <= 1'b1;
        end else begin
          delay <= delay - 2'd1;
        end
      end
    end else if (rsp_q.rvalid) begin
      // beat held until rready
      if (mem_req.rready) begin
        rsp_q.rvalid <= 1'b0;
        rsp_q.rlast <= 1'b0;
        busy <= !rsp_q.rlast;
        addr <= (addr & ~wrap_mask) | ((addr + 32'd4) & wrap_mask);
        beats_left <= beats_left - 8'd1;
        rng <= xorshift(rng);
        delay <= rng[1:0];
      end
    end else if (delay == 2'd0) begin
      rsp_q.rvalid <= 1'b1;
      rsp_q.rdata <= mem_word(addr);
      rsp_q.rlast <= (beats_left == 8'd0);
    end else begin
      delay <= delay - 2'd1;
    end
  end

  assign mem_rsp = rsp_q;

endmodule

`default_nettype wire

// ==== testbench/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  // about 300 requests at a worst refill near 70 cycles, plus margin
  localparam int max_cycles = 40000;
  localparam int random_requests = 250;
  localparam logic [31:0] seed = 32'hd7a1_2435;

  logic         clock;
  logic         reset;
  logic [31:0]  fetch_addr;
  logic         fetch_valid;
  logic         fetch_ready;
  logic         result_valid;
  logic [31:0]  fetch_data;
  logic         fencei;
  axi_r_m2s_t   mem_req;
  axi_r_s2m_t   mem_rsp;
  perf_counts_t counts;

  // tag and valid mirror of the 16 lines
  logic [15:0]         mirror_valid;
  logic [tag_bits-1:0] mirror_tag [16];
  perf_counts_t        exp_counts;
  axi_r_m2s_t          expected_req;
  logic [31:0]         rng;

  logic [31:0] expected_word = '0;
  int          request_id = 0;
  int          checked_id = 0;
  int          word_checks = 0;
  int          word_errors = 0;
  int          count_checks = 0;
  int          count_errors = 0;
  int          ar_count = 0;
  int          expected_ars = 0;
  int          request_errors = 0;
  int          errors_before = 0;
  string       waiting_for = "reset";

  icache_top u_dut (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .result_valid (result_valid),
    .fetch_data   (fetch_data),
    .fencei       (fencei),
    .mem_req      (mem_req),
    .mem_rsp      (mem_rsp),
    .counts       (counts)
  );

  axi_read_model u_mem (
    .clock   (clock),
    .reset   (reset),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] byte_addr);
    logic [31:0] h;
    h = {2'b00, byte_addr[31:2]} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    h = h * 32'h85eb_ca6b;
    return h ^ (h >> 13);
  endfunction

  function automatic logic [31:0] random_addr(input logic [31:0] r);
    logic [31:0] base;
    case (r % 32'd3)
      32'd0: base = r[24] ? 32'h1000_0000 : 32'h0000_0000;
      32'd1: base = r[24] ? 32'h9fff_f800 : 32'h3000_0000;
      default: base = r[24] ? 32'hffff_f800 : 32'ha000_0000;
    endcase
    return base | {21'd0, r[10:2], 2'b00};
  endfunction

  task automatic check_word(input logic [31:0] expected);
    word_checks = word_checks + 1;
    if (fetch_data !== expected) begin
      $display("Mismatch at %0t: fetch_data got %h expected %h", $time, fetch_data, expected);
      word_errors = word_errors + 1;
    end
  endtask

  task automatic check_counts(input perf_counts_t expected);
    count_checks = count_checks + 1;
    if (counts.hits !== expected.hits) begin
      $display("Mismatch at %0t: counts.hits got %0d expected %0d",
               $time, counts.hits, expected.hits);
      count_errors = count_errors + 1;
    end
    if (counts.misses !== expected.misses) begin
      $display("Mismatch at %0t: counts.misses got %0d expected %0d",
               $time, counts.misses, expected.misses);
      count_errors = count_errors + 1;
    end
    if (counts.skips !== expected.skips) begin
      $display("Mismatch at %0t: counts.skips got %0d expected %0d",
               $time, counts.skips, expected.skips);
      count_errors = count_errors + 1;
    end
  endtask

  task automatic check_request(input axi_r_m2s_t expected);
    if (mem_req.arlen !== expected.arlen) begin
      $display("Mismatch at %0t: mem_req.arlen got %0d expected %0d",
               $time, mem_req.arlen, expected.arlen);
      request_errors = request_errors + 1;
    end
    if (mem_req.arsize !== expected.arsize) begin
      $display("Mismatch at %0t: mem_req.arsize got %0d expected %0d",
               $time, mem_req.arsize, expected.arsize);
      request_errors = request_errors + 1;
    end
  endtask

  // every returned word is compared against the memory hash
  always @(negedge clock) begin
    if (!reset && result_valid) begin
      if (checked_id == request_id) begin
        $display("Error at %0t: result_valid with no request pending", $time);
        word_errors = word_errors + 1;
      end else begin
        check_word(expected_word);
        checked_id = request_id;
      end
    end
  end

  // AR handshake completes at the next rising edge
  always @(negedge clock) begin
    if (!reset && mem_req.arvalid && mem_rsp.arready) begin
      check_request(expected_req);
      ar_count = ar_count + 1;
    end
  end

  task automatic issue_request(input logic [31:0] addr);
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    index = addr[line_offset_bits +: index_bits];
    tag = addr[31 -: tag_bits];
    if (addr < skip_limit) begin
      exp_counts.skips = exp_counts.skips + 32'd1;
      expected_ars = expected_ars + 1;
    end else if (mirror_valid[index] && mirror_tag[index] == tag) begin
      exp_counts.hits = exp_counts.hits + 32'd1;
    end else begin
      exp_counts.misses = exp_counts.misses + 32'd1;
      mirror_valid[index] = 1'b1;
      mirror_tag[index] = tag;
      // one wrapping burst, or eight single reads from flash
      expected_ars = expected_ars + ((addr >= burst_base) ? 1 : words_per_line);
    end
    waiting_for = "fetch_ready";
    @(posedge clock);
    fetch_addr <= addr;
    fetch_valid <= 1'b1;
    expected_word = mem_word(addr);
    request_id = request_id + 1;
    @(negedge clock);
    while (!fetch_ready) @(negedge clock);
    expected_req.arlen = (addr >= burst_base) ? 8'd7 : 8'd0;
    @(posedge clock);
    fetch_valid <= 1'b0;
    waiting_for = "result_valid";
    @(negedge clock);
    while (!result_valid) @(negedge clock);
    waiting_for = "nothing";
  endtask

  task automatic read_line(input logic [31:0] base);
    for (int w = 0; w < words_per_line; w++) begin
      issue_request(base | (32'(w) << 2));
    end
  endtask

  // counters trail the accept by two cycles
  task automatic wait_idle();
    waiting_for = "fetch_ready";
    @(negedge clock);
    while (!fetch_ready) @(negedge clock);
    repeat (2) @(negedge clock);
    waiting_for = "nothing";
  endtask

  task automatic pulse_fencei();
    wait_idle();
    @(posedge clock);
    fencei <= 1'b1;
    @(posedge clock);
    fencei <= 1'b0;
    mirror_valid = '0;
  endtask

  task automatic finish_test(input string name);
    int total;
    wait_idle();
    check_counts(exp_counts);
    if (ar_count != expected_ars) begin
      $display("Mismatch at %0t: mem_req.arvalid handshakes got %0d expected %0d",
               $time, ar_count, expected_ars);
      request_errors = request_errors + 1;
    end
    total = word_errors + count_errors + request_errors;
    if (total == errors_before) begin
      $display("%s: passed", name);
    end else begin
      $display("%s: %0d errors", name, total - errors_before);
    end
    errors_before = total;
  endtask

  initial begin
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clock);
      cycle_count = cycle_count + 1;
    end
    $display("Timeout after %0d cycles while waiting for %s", max_cycles, waiting_for);
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] last_addr;
    reset <= 1'b1;
    fetch_valid <= 1'b0;
    fetch_addr <= '0;
    fencei <= 1'b0;
    exp_counts = '0;
    expected_req = '0;
    expected_req.arsize = word_size_code;
    mirror_valid = '0;
    rng = seed;
    last_addr = burst_base;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    finish_test("reset state");

    issue_request(32'h0000_0100);
    issue_request(32'h2fff_fffc);
    issue_request(32'h0000_0100);
    issue_request(32'h2fff_fffc);
    finish_test("test 1 skip region");

    // word 5 of line 2 comes first
    issue_request(32'ha000_0054);
    read_line(32'ha000_0040);
    finish_test("test 2 burst refill");

    issue_request(32'h4000_0188);
    read_line(32'h4000_0180);
    finish_test("test 3 flash refill");

    // both map to index 0
    issue_request(32'ha000_0200);
    issue_request(32'h5000_0204);
    issue_request(32'ha000_0208);
    issue_request(32'h5000_020c);
    issue_request(32'h5000_0200);
    finish_test("test 4 eviction");

    issue_request(32'hb000_0060);
    issue_request(32'hb000_0064);
    pulse_fencei();
    issue_request(32'hb000_0060);
    issue_request(32'ha000_0054);
    issue_request(32'hb000_007c);
    finish_test("test 5 fencei");

    // some requests stay in the last line to get hits
    for (int i = 0; i < random_requests; i++) begin
      rng = xorshift(rng);
      if (rng[27]) begin
        addr = {last_addr[31:line_offset_bits], rng[4:2], 2'b00};
      end else begin
        addr = random_addr(rng);
      end
      issue_request(addr);
      last_addr = addr;
    end
    finish_test("test 6 random requests");

    $display("word checks: %0d, count checks: %0d, errors: %0d",
             word_checks, count_checks, word_errors + count_errors + request_errors);
    if (word_errors + count_errors + request_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
